//--- Makefile
# Verilator simulation of the clock infrastructure

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f roach_infra.f --top-module roach_infra_tb -o roach_infra_sim
	@out="$$(./obj_dir/roach_infra_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- dv/roach_infra_checker.sv
`timescale 1ns/1ps

module roach_infra_checker (
  input logic                     sys_clk,
  input logic                     arst_n,
  input logic                     wb_cyc,
  input logic                     wb_stb,
  input logic                     wb_ack,
  input clk_infra_pkg::lock_vec_t lock_vec,
  input logic                     aux0_rst,
  input logic                     aux1_rst,
  input logic                     dly_rst
);

  // Single wait state, so ack is a one cycle pulse
  a_ack_one_cycle: assert property (@(posedge sys_clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack) else $error("wb_ack stayed high for two cycles");

  a_ack_after_stb: assert property (@(posedge sys_clk) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb)) else $error("wb_ack without a strobe before it");

  // Unlocked domain is held in reset
  a_rst_aux0: assert property (@(posedge sys_clk) disable iff (!arst_n)
    !lock_vec[0] |-> aux0_rst) else $error("aux0_rst low while aux0 is unlocked");

  a_rst_aux1: assert property (@(posedge sys_clk) disable iff (!arst_n)
    !lock_vec[1] |-> aux1_rst) else $error("aux1_rst low while aux1 is unlocked");

  a_rst_dly: assert property (@(posedge sys_clk) disable iff (!arst_n)
    !lock_vec[2] |-> dly_rst) else $error("dly_rst low while dly is unlocked");

endmodule

bind roach_infrastructure roach_infra_checker u_checker (
  .sys_clk, .arst_n, .wb_cyc, .wb_stb, .wb_ack,
  .lock_vec, .aux0_rst, .aux1_rst, .dly_rst
);

//--- dv/roach_infra_tb.sv
`timescale 1ns/1ps
`include "roach_infra_cfg.svh"

module roach_infra_tb;
  import clk_infra_pkg::*;
  import infra_regs_pkg::*;

  localparam int WIN = `INFRA_WINDOW;
  localparam int LOCK_BOUND = (`INFRA_LOCK_RUN + 2) * WIN;
  // Slowest domain clock period is 120 ns or 15 sys_clk cycles
  localparam int RST_BOUND = (`INFRA_RST_STRETCH + 4) * 15;
  localparam int CAL_BOUND = (`INFRA_CALIB_DELAY + 8) * 15;
  localparam int CYCLE_LIMIT = 6 * 12 * WIN;

  logic        sys_clk;
  logic        aux0_clk;
  logic        aux1_clk;
  logic        dly_clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        aux0_rst;
  logic        aux1_rst;
  logic        dly_rst;
  logic        idelay_rdy;
  logic        locked;
  logic [2:0]  rst_vec;
  logic        clk_go;
  integer      seed;
  int          half_ns [3];
  int          ideal [3];
  int          cycle_cnt;
  int          checks;
  int          errors;
  int          ack_count;
  int          xfer_count;

  assign rst_vec = {dly_rst, aux1_rst, aux0_rst};

  roach_infrastructure u_roach_infrastructure (
    .sys_clk, .aux0_clk, .aux1_clk, .dly_clk, .arst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .aux0_rst, .aux1_rst, .dly_rst, .idelay_rdy, .locked
  );

  ////////////////////////////////////////////////////////////
  // Clocks, cycle limit and ack count
  ////////////////////////////////////////////////////////////

  always #4 sys_clk = ~sys_clk;

  // Domain clocks start half a ns off the sys_clk grid
  always begin
    wait (clk_go);
    #(half_ns[0]) aux0_clk = ~aux0_clk;
  end

  always begin
    wait (clk_go);
    #(half_ns[1]) aux1_clk = ~aux1_clk;
  end

  always begin
    wait (clk_go);
    #(half_ns[2]) dly_clk = ~dly_clk;
  end

  always @(posedge sys_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not end within %0d sys_clk cycles", CYCLE_LIMIT);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Test failed");
      $finish;
    end
  end

  always @(negedge sys_clk) begin
    if (wb_ack === 1'b1) begin
      ack_count = ack_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Model, compare and bus tasks
  ////////////////////////////////////////////////////////////

  // Edges of a clock in one window rounded to the nearest
  function automatic int ideal_count(input int half);
    int period;
    period = 2 * half;
    return (WIN * 8 + period / 2) / period;
  endfunction

  // Count error beyond the tolerance, zero when accepted
  function automatic logic [31:0] count_excess(input logic [31:0] got, input int model);
    int err;
    err = int'(got) - model;
    if (err < 0) begin
      err = -err;
    end
    if (err <= `INFRA_TOL) begin
      return 32'd0;
    end
    return 32'(err - `INFRA_TOL);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic wb_xfer(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                         output logic [31:0] rdata);
    int n;
    @(negedge sys_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    n = 0;
    do begin
      @(negedge sys_clk);
      n++;
    end while (!wb_ack && n < 8);
    rdata = wb_dat_r;
    if (!wb_ack) begin
      $display("ERROR: no ack for the transfer to address %0d", adr);
      errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    xfer_count++;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
    wb_xfer(1'b0, adr, 32'd0, data);
  endtask

  // Poll STATUS until the masked bits match
  task automatic wait_status(input logic [3:0] mask, input logic [3:0] value,
                             input int max_cycles, input string what);
    logic [31:0] st;
    int          start;
    bit          done;
    start = cycle_cnt;
    done  = 1'b0;
    while (!done && (cycle_cnt - start) < max_cycles) begin
      wb_read(ADDR_STATUS, st);
      done = ((st[3:0] & mask) == value);
    end
    checks++;
    if (!done) begin
      $display("ERROR: %s not seen within %0d cycles", what, max_cycles);
      errors++;
    end
  endtask

  task automatic wait_resets(input logic [2:0] value, input int max_cycles, input string what);
    int n;
    n = 0;
    while (rst_vec !== value && n < max_cycles) begin
      @(negedge sys_clk);
      n++;
    end
    checks++;
    if (rst_vec !== value) begin
      $display("ERROR: %s not seen within %0d cycles", what, max_cycles);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    ctrl_word_u  word;
    logic [2:0]  good_mask;
    logic [9:0]  exp_model [1:3];
    int          i;
    int          ch;
    int          offset;
    int          addr;
    seed       = 32'h4c6db1e5;
    sys_clk    = 1'b0;
    aux0_clk   = 1'b0;
    aux1_clk   = 1'b0;
    dly_clk    = 1'b0;
    clk_go     = 1'b0;
    arst_n     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    cycle_cnt  = 0;
    checks     = 0;
    errors     = 0;
    ack_count  = 0;
    xfer_count = 0;
    for (i = 0; i < 3; i++) begin
      half_ns[i] = 20 + ($unsigned($random(seed)) % 41);
      ideal[i]   = ideal_count(half_ns[i]);
    end
    #0.5;
    clk_go = 1'b1;
    repeat (10) @(negedge sys_clk);
    arst_n = 1'b1;

    // Idle state after reset
    @(negedge sys_clk);
    check("wb_ack", wb_ack, 0);
    check("locked", locked, 0);
    check("idelay_rdy", idelay_rdy, 0);
    check("dom_rst", rst_vec, 3'b111);
    wb_read(ADDR_STATUS, rd);
    check("status.lock", rd[2:0], 0);
    wait_status(4'b1000, 4'b1000, CAL_BOUND, "idelay_rdy after reset");
    check("idelay_rdy", idelay_rdy, 1);

    // Program ideal counts and wait for lock
    for (i = 0; i < 3; i++) begin
      word = '0;
      word.expv.count = edge_cnt_t'(ideal[i]);
      exp_model[i + 1] = word.expv.count;
      wb_write(3'(1 + i), word);
    end
    wait_status(4'b0111, 4'b0111, LOCK_BOUND, "lock on all channels");
    @(negedge sys_clk);
    check("locked", locked, 1);
    wait_resets(3'b000, RST_BOUND, "release of all domain resets");
    for (i = 0; i < 3; i++) begin
      wb_read(3'(4 + i), rd);
      check($sformatf("cnt[%0d] beyond tolerance", i), count_excess(rd, ideal[i]), 0);
    end

    // Detune one channel beyond the tolerance
    ch     = $unsigned($random(seed)) % 3;
    offset = `INFRA_TOL + 3 + ($unsigned($random(seed)) % 8);
    word   = '0;
    word.expv.count = edge_cnt_t'(ideal[ch] + offset);
    exp_model[ch + 1] = word.expv.count;
    wb_write(3'(1 + ch), word);
    good_mask = 3'b111 & ~(3'b001 << ch);
    wait_status(4'b0111, {1'b0, good_mask}, 3 * WIN, "lock loss on the detuned channel");
    @(negedge sys_clk);
    check("locked", locked, 0);
    check("dom_rst", rst_vec, {29'd0, ~good_mask});

    // Clear drops every lock and good channels come back
    word = '0;
    word.cmdv.monitor_clear = 1'b1;
    wb_write(ADDR_CMD, word);
    wb_read(ADDR_STATUS, rd);
    check("status.lock", rd[2:0], 0);
    wait_status(4'b0111, {1'b0, good_mask}, LOCK_BOUND, "relock after monitor_clear");
    wait_resets(~good_mask, RST_BOUND, "domain resets after relock");

    // Calibration reset and recovery
    word = '0;
    word.cmdv.calib_rst = 1'b1;
    wb_write(ADDR_CMD, word);
    wb_read(ADDR_STATUS, rd);
    check("status.idelay_rdy", rd[3], 0);
    check("idelay_rdy", idelay_rdy, 0);
    wb_write(ADDR_CMD, 32'd0);
    wait_status(4'b1000, 4'b1000, CAL_BOUND, "idelay_rdy after calibration release");
    check("idelay_rdy", idelay_rdy, 1);

    // Random traffic on the EXP registers
    for (i = 0; i < 24; i++) begin
      addr = 1 + ($unsigned($random(seed)) % 3);
      if ($random(seed) & 1) begin
        word = $random(seed);
        exp_model[addr] = word.expv.count;
        wb_write(3'(addr), word);
      end else begin
        wb_read(3'(addr), rd);
        check($sformatf("exp[%0d]", addr), rd, {22'd0, exp_model[addr]});
      end
    end
    @(negedge sys_clk);
    check("ack_count", ack_count, xfer_count);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- include/roach_infra_cfg.svh
`ifndef ROACH_INFRA_CFG_SVH
`define ROACH_INFRA_CFG_SVH

// Measurement window, in sys_clk cycles
`define INFRA_WINDOW 256

// Good windows in a row before lock
`define INFRA_LOCK_RUN 3

// Allowed count error, in edges
`define INFRA_TOL 2

// Domain clock cycles a reset is held after lock
`define INFRA_RST_STRETCH 8

// dly_clk cycles from calibration release to ready
`define INFRA_CALIB_DELAY 32

// Wishbone word address width
`define INFRA_ADR_W 3

`endif

//--- roach_infra.f
+incdir+include
source/clk_infra_pkg.sv
source/infra_regs_pkg.sv
source/clk_freq_monitor.sv
source/domain_reset_sync.sv
source/idelay_calib_ctrl.sv
source/infra_wb_regs.sv
source/roach_infrastructure.sv
dv/roach_infra_checker.sv
dv/roach_infra_tb.sv

//--- source/clk_freq_monitor.sv
`timescale 1ns/1ps
`include "roach_infra_cfg.svh"

module clk_freq_monitor (
  input  logic                     sys_clk,
  input  logic                     arst_n,
  input  logic                     mon_clk,
  input  logic                     monitor_clear,
  input  clk_infra_pkg::edge_cnt_t exp_count,
  output clk_infra_pkg::edge_cnt_t meas_count,
  output logic                     lock
);
  import clk_infra_pkg::*;

  localparam int WIN_W = $clog2(`INFRA_WINDOW);
  localparam int RUN_W = $clog2(`INFRA_LOCK_RUN + 1);
  localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`INFRA_WINDOW - 1);
  localparam logic [RUN_W-1:0] RUN_LAST = RUN_W'(`INFRA_LOCK_RUN - 1);
  localparam edge_cnt_t TOL = edge_cnt_t'(`INFRA_TOL);

  logic [2:0]       mon_q;
  logic             rise;
  logic             win_end;
  logic             good;
  logic [WIN_W-1:0] win_cnt;
  logic [RUN_W-1:0] run_cnt;
  edge_cnt_t        edge_cnt;
  edge_cnt_t        win_total;
  edge_cnt_t        diff;

  // Two sync flops, third one for edge detect
  assign rise    = mon_q[1] & ~mon_q[2];
  assign win_end = (win_cnt == WIN_LAST);

  // Count including an edge on the closing cycle
  assign win_total = edge_cnt + edge_cnt_t'(rise);
  assign diff      = (win_total >= exp_count) ? win_total - exp_count
                                              : exp_count - win_total;
  // Unprogrammed channel never locks
  assign good      = (exp_count != '0) && (diff <= TOL);

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      mon_q      <= '0;
      win_cnt    <= '0;
      edge_cnt   <= '0;
      run_cnt    <= '0;
      meas_count <= '0;
      lock       <= 1'b0;
    end else begin
      mon_q <= {mon_q[1:0], mon_clk};
      if (monitor_clear) begin
        // Restart with a fresh window
        win_cnt  <= '0;
        edge_cnt <= '0;
        run_cnt  <= '0;
        lock     <= 1'b0;
      end else if (win_end) begin
        win_cnt    <= '0;
        edge_cnt   <= '0;
        meas_count <= win_total;
        if (good) begin
          lock <= (run_cnt == RUN_LAST);
          if (run_cnt != RUN_LAST) begin
            run_cnt <= run_cnt + 1'b1;
          end
        end else begin
          run_cnt <= '0;
          lock    <= 1'b0;
        end
      end else begin
        win_cnt  <= win_cnt + 1'b1;
        edge_cnt <= win_total;
      end
    end
  end

endmodule

//--- source/clk_infra_pkg.sv
package clk_infra_pkg;

  ////////////////////////////////////////////////////////////
  // Monitored clock channels
  ////////////////////////////////////////////////////////////

  // Channel index, also the bit position in a lock vector
  typedef enum logic [1:0] {
    AUX0 = 2'd0,
    AUX1 = 2'd1,
    DLY  = 2'd2
  } clk_chan_e;

  // Rising edges seen in one window
  typedef logic [9:0] edge_cnt_t;

  // One lock flag per channel
  typedef logic [2:0] lock_vec_t;

endpackage

//--- source/domain_reset_sync.sv
`timescale 1ns/1ps
`include "roach_infra_cfg.svh"

module domain_reset_sync (
  input  logic dom_clk,
  input  logic arst_n,
  input  logic lock,
  output logic dom_rst
);

  localparam int STR_W = $clog2(`INFRA_RST_STRETCH + 1);
  localparam logic [STR_W-1:0] STR_LAST = STR_W'(`INFRA_RST_STRETCH - 1);

  logic             clr_n;
  logic [1:0]       sync_q;
  logic [STR_W-1:0] stretch_cnt;

  // Loss of lock asserts reset right away
  assign clr_n = arst_n & lock;

  always_ff @(posedge dom_clk or negedge clr_n) begin
    if (!clr_n) begin
      sync_q      <= '0;
      stretch_cnt <= '0;
      dom_rst     <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
      // Hold a few more cycles once release is synchronized
      if (sync_q[1]) begin
        if (stretch_cnt == STR_LAST) begin
          dom_rst <= 1'b0;
        end else begin
          stretch_cnt <= stretch_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- source/idelay_calib_ctrl.sv
`timescale 1ns/1ps
`include "roach_infra_cfg.svh"

module idelay_calib_ctrl (
  input  logic dly_clk,
  input  logic sys_clk,
  input  logic arst_n,
  input  logic calib_rst,
  output logic idelay_rdy
);

  localparam int CNT_W = $clog2(`INFRA_CALIB_DELAY + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`INFRA_CALIB_DELAY - 1);

  logic             clr_n;
  logic [1:0]       rst_sync_q;
  logic [CNT_W-1:0] cal_cnt;
  logic             rdy_dly;
  logic [1:0]       rdy_sync_q;

  assign clr_n = arst_n & ~calib_rst;

  ////////////////////////////////////////////////////////////
  // dly_clk domain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge dly_clk or negedge clr_n) begin
    if (!clr_n) begin
      rst_sync_q <= '0;
      cal_cnt    <= '0;
      rdy_dly    <= 1'b0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
      if (rst_sync_q[1] && !rdy_dly) begin
        if (cal_cnt == CNT_LAST) begin
          rdy_dly <= 1'b1;
        end else begin
          cal_cnt <= cal_cnt + 1'b1;
        end
      end
    end
  end

  // Back to sys_clk, cleared at once by calib_rst
  always_ff @(posedge sys_clk or negedge clr_n) begin
    if (!clr_n) begin
      rdy_sync_q <= '0;
    end else begin
      rdy_sync_q <= {rdy_sync_q[0], rdy_dly};
    end
  end

  assign idelay_rdy = rdy_sync_q[1];

endmodule

//--- source/infra_regs_pkg.sv
`include "roach_infra_cfg.svh"

package infra_regs_pkg;

  // Word addresses on the processor bus
  typedef enum logic [`INFRA_ADR_W-1:0] {
    ADDR_STATUS   = 3'd0,
    ADDR_EXP_AUX0 = 3'd1,
    ADDR_EXP_AUX1 = 3'd2,
    ADDR_EXP_DLY  = 3'd3,
    ADDR_CNT_AUX0 = 3'd4,
    ADDR_CNT_AUX1 = 3'd5,
    ADDR_CNT_DLY  = 3'd6,
    ADDR_CMD      = 3'd7
  } reg_addr_e;

  // One write word, seen as an expected count or as a command
  typedef union packed {
    struct packed {
      logic [31-$bits(clk_infra_pkg::edge_cnt_t):0] pad;
      clk_infra_pkg::edge_cnt_t                      count;
    } expv;
    struct packed {
      logic [29:0] pad;
      logic        calib_rst;
      logic        monitor_clear;
    } cmdv;
  } ctrl_word_u;

endpackage

//--- source/infra_wb_regs.sv
`timescale 1ns/1ps
`include "roach_infra_cfg.svh"

module infra_wb_regs (
  input  logic                     sys_clk,
  input  logic                     arst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`INFRA_ADR_W-1:0]  wb_adr,
  input  logic [31:0]              wb_dat_w,
  input  clk_infra_pkg::edge_cnt_t meas_count_aux0,
  input  clk_infra_pkg::edge_cnt_t meas_count_aux1,
  input  clk_infra_pkg::edge_cnt_t meas_count_dly,
  input  clk_infra_pkg::lock_vec_t lock,
  input  logic                     idelay_rdy,
  output logic [31:0]              wb_dat_r,
  output logic                     wb_ack,
  output clk_infra_pkg::edge_cnt_t exp_aux0,
  output clk_infra_pkg::edge_cnt_t exp_aux1,
  output clk_infra_pkg::edge_cnt_t exp_dly,
  output logic                     monitor_clear,
  output logic                     calib_rst
);
  import clk_infra_pkg::*;
  import infra_regs_pkg::*;

  localparam int PAD_W = 32 - $bits(edge_cnt_t);

  logic        req;
  reg_addr_e   addr;
  ctrl_word_u  wr_word;
  logic [31:0] rd_data;

  // New cycle only while ack is low, giving one wait state
  assign req     = wb_cyc & wb_stb & ~wb_ack;
  assign addr    = reg_addr_e'(wb_adr);
  assign wr_word = wb_dat_w;

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (addr)
      ADDR_STATUS:   rd_data = {28'd0, idelay_rdy, lock};
      ADDR_EXP_AUX0: rd_data = {{PAD_W{1'b0}}, exp_aux0};
      ADDR_EXP_AUX1: rd_data = {{PAD_W{1'b0}}, exp_aux1};
      ADDR_EXP_DLY:  rd_data = {{PAD_W{1'b0}}, exp_dly};
      ADDR_CNT_AUX0: rd_data = {{PAD_W{1'b0}}, meas_count_aux0};
      ADDR_CNT_AUX1: rd_data = {{PAD_W{1'b0}}, meas_count_aux1};
      ADDR_CNT_DLY:  rd_data = {{PAD_W{1'b0}}, meas_count_dly};
      default:       rd_data = {30'd0, calib_rst, 1'b0};
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Ack and writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack        <= 1'b0;
      exp_aux0      <= '0;
      exp_aux1      <= '0;
      exp_dly       <= '0;
      monitor_clear <= 1'b0;
      calib_rst     <= 1'b0;
    end else begin
      wb_ack        <= req;
      monitor_clear <= 1'b0;
      if (req && wb_we) begin
        case (addr)
          ADDR_EXP_AUX0: exp_aux0 <= wr_word.expv.count;
          ADDR_EXP_AUX1: exp_aux1 <= wr_word.expv.count;
          ADDR_EXP_DLY:  exp_dly  <= wr_word.expv.count;
          ADDR_CMD: begin
            monitor_clear <= wr_word.cmdv.monitor_clear;
            calib_rst     <= wr_word.cmdv.calib_rst;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- source/roach_infrastructure.sv
`timescale 1ns/1ps
`include "roach_infra_cfg.svh"

module roach_infrastructure (
  input  logic                    sys_clk,
  input  logic                    aux0_clk,
  input  logic                    aux1_clk,
  input  logic                    dly_clk,
  input  logic                    arst_n,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`INFRA_ADR_W-1:0] wb_adr,
  input  logic [31:0]             wb_dat_w,
  output logic [31:0]             wb_dat_r,
  output logic                    wb_ack,
  output logic                    aux0_rst,
  output logic                    aux1_rst,
  output logic                    dly_rst,
  output logic                    idelay_rdy,
  output logic                    locked
);
  import clk_infra_pkg::*;

  edge_cnt_t exp_aux0;
  edge_cnt_t exp_aux1;
  edge_cnt_t exp_dly;
  edge_cnt_t cnt_aux0;
  edge_cnt_t cnt_aux1;
  edge_cnt_t cnt_dly;
  lock_vec_t lock_vec;
  logic      monitor_clear;
  logic      calib_rst;

  assign locked = &lock_vec;

  ////////////////////////////////////////////////////////////
  // Lock monitors, all measured against sys_clk
  ////////////////////////////////////////////////////////////

  clk_freq_monitor u_mon_aux0 (
    .sys_clk, .arst_n, .mon_clk(aux0_clk), .monitor_clear,
    .exp_count(exp_aux0), .meas_count(cnt_aux0), .lock(lock_vec[AUX0])
  );

  clk_freq_monitor u_mon_aux1 (
    .sys_clk, .arst_n, .mon_clk(aux1_clk), .monitor_clear,
    .exp_count(exp_aux1), .meas_count(cnt_aux1), .lock(lock_vec[AUX1])
  );

  clk_freq_monitor u_mon_dly (
    .sys_clk, .arst_n, .mon_clk(dly_clk), .monitor_clear,
    .exp_count(exp_dly), .meas_count(cnt_dly), .lock(lock_vec[DLY])
  );

  // Per domain resets
  domain_reset_sync u_rst_aux0 (
    .dom_clk(aux0_clk), .arst_n, .lock(lock_vec[AUX0]), .dom_rst(aux0_rst)
  );

  domain_reset_sync u_rst_aux1 (
    .dom_clk(aux1_clk), .arst_n, .lock(lock_vec[AUX1]), .dom_rst(aux1_rst)
  );

  domain_reset_sync u_rst_dly (
    .dom_clk(dly_clk), .arst_n, .lock(lock_vec[DLY]), .dom_rst(dly_rst)
  );

  idelay_calib_ctrl u_calib (
    .dly_clk, .sys_clk, .arst_n, .calib_rst, .idelay_rdy
  );

  infra_wb_regs u_regs (
    .sys_clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .meas_count_aux0(cnt_aux0), .meas_count_aux1(cnt_aux1),
    .meas_count_dly(cnt_dly), .lock(lock_vec), .idelay_rdy,
    .wb_dat_r, .wb_ack, .exp_aux0, .exp_aux1, .exp_dly,
    .monitor_clear, .calib_rst
  );

endmodule
